// File: common/bb_pkg.sv
package bb_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int APB_AW    = 32;  // APB address
    localparam int APB_DW    = 32;  // APB data
    localparam int USB_DW    = 32;  // USB stream word
    localparam int USB_BEW   = 4;   // USB byte enables
    localparam int ADC_DW    = 8;   // ADC sample
    localparam int LED_DEPTH = 16;  // Dimmer accumulator
    localparam int IOEXP_W   = 16;  // Expander word

    //////////////////////////////
    // Address map
    //////////////////////////////

    localparam logic [19:0] BOARD_BASE = 20'h43C00;  // Peripheral region, addr 31:12
    localparam logic [3:0]  REGS_PAGE  = 4'h4;       // Page in addr 15:12

    localparam logic [11:0] REG_CTRL      = 12'h000;
    localparam logic [11:0] REG_LED0      = 12'h004;
    localparam logic [11:0] REG_LED1      = 12'h008;
    localparam logic [11:0] REG_USB_WDATA = 12'h00C;  // Push only
    localparam logic [11:0] REG_STATUS    = 12'h010;  // Live FIFO flags
    localparam logic [11:0] REG_FE_CTRL   = 12'h014;

    // Expander frame, 16 bits at 2 cycles plus 2 idle
    localparam int IOEXP_FRAME = 34;
    localparam int IOEXP_CW    = $clog2(IOEXP_FRAME);

    // USB write stream source
    typedef enum logic [1:0] {
        SRC_REGS = 2'd0,  // Raw register push
        SRC_IDLE = 2'd1,
        SRC_ADC  = 2'd2,  // Channel A samples
        SRC_LOOP = 2'd3   // Read stream echoed back
    } usb_src_e;

    typedef struct packed {
        logic              sel;
        logic              enable;
        logic              write;
        logic [APB_AW-1:0] addr;
        logic [APB_DW-1:0] wdata;
    } apb_req_t;

    typedef struct packed {
        logic [USB_DW-1:0]  data;
        logic [USB_BEW-1:0] be;
        logic               valid;
    } usb_word_t;

    typedef struct packed {
        logic [1:0] att;     // Attenuator steps
        logic       amp_en;
        logic [2:0] led;     // Red, green, blue
    } fe_ctrl_t;

    typedef struct packed {
        usb_src_e             usb_src;
        logic                 i2c_sel;
        logic                 dac_dce;
        logic [LED_DEPTH-1:0] led0;
        logic [LED_DEPTH-1:0] led1;
        fe_ctrl_t             fe_a;
        fe_ctrl_t             fe_b;
    } bb_cfg_t;

endpackage

// File: regs/bb_regs.sv
`timescale 1ns/1ps

module bb_regs (
    input  logic                      clk,
    input  logic                      reset_i,
    input  bb_pkg::apb_req_t          apb_i,
    input  logic                      usb_wr_full_i,
    input  logic                      usb_rd_empty_i,
    output logic [bb_pkg::APB_DW-1:0] apb_rdata_o,
    output bb_pkg::bb_cfg_t           cfg_o,
    output bb_pkg::usb_word_t         usb_raw_o
);

    logic        page_hit;   // Board base and page 4 match
    logic [11:0] offset;     // Byte offset inside the page
    logic        wr_stb;     // Write edge strobe
    logic        push_stb;   // Write to REG_USB_WDATA

    bb_pkg::bb_cfg_t           cfg_q;
    logic                      raw_valid_q;
    logic [bb_pkg::USB_DW-1:0] raw_data_q;

    //////////////////////////////
    // Page and offset decode
    //////////////////////////////

    assign page_hit = (apb_i.addr[bb_pkg::APB_AW-1:16] == bb_pkg::BOARD_BASE[19:4])
                   && (apb_i.addr[15:12] == bb_pkg::REGS_PAGE);
    assign offset   = apb_i.addr[11:0];
    assign wr_stb   = apb_i.sel && apb_i.enable && apb_i.write && page_hit;  // Access phase
    assign push_stb = wr_stb && (offset == bb_pkg::REG_USB_WDATA);

    // Register file
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q <= '0;  // usb_src comes up as SRC_REGS
        end else if (wr_stb) begin
            case (offset)
                bb_pkg::REG_CTRL: begin
                    cfg_q.usb_src <= bb_pkg::usb_src_e'(apb_i.wdata[1:0]);
                    cfg_q.i2c_sel <= apb_i.wdata[4];
                    cfg_q.dac_dce <= apb_i.wdata[8];
                end
                bb_pkg::REG_LED0:    cfg_q.led0 <= apb_i.wdata[bb_pkg::LED_DEPTH-1:0];
                bb_pkg::REG_LED1:    cfg_q.led1 <= apb_i.wdata[bb_pkg::LED_DEPTH-1:0];
                bb_pkg::REG_FE_CTRL: begin
                    cfg_q.fe_a <= bb_pkg::fe_ctrl_t'(apb_i.wdata[5:0]);
                    cfg_q.fe_b <= bb_pkg::fe_ctrl_t'(apb_i.wdata[13:8]);
                end
                default: ;  // Status and push hold no settings
            endcase
        end
    end

    assign cfg_o = cfg_q;

    //////////////////////////////
    // Raw USB push
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            raw_valid_q <= 1'b0;
        end else begin
            raw_valid_q <= push_stb;  // One cycle per write
        end
    end

    always_ff @(posedge clk) begin
        if (push_stb) begin
            raw_data_q <= apb_i.wdata;
        end
    end

    always_comb begin
        usb_raw_o.data  = raw_data_q;
        usb_raw_o.be    = '1;          // Whole word
        usb_raw_o.valid = raw_valid_q;
    end

    // Read mux, page fold included
    always_comb begin
        apb_rdata_o = '0;  // Other pages and holes read 0
        if (apb_i.sel && apb_i.enable && page_hit) begin
            case (offset)
                bb_pkg::REG_CTRL: begin
                    apb_rdata_o[1:0] = cfg_q.usb_src;
                    apb_rdata_o[4]   = cfg_q.i2c_sel;
                    apb_rdata_o[8]   = cfg_q.dac_dce;
                end
                bb_pkg::REG_LED0:    apb_rdata_o[bb_pkg::LED_DEPTH-1:0] = cfg_q.led0;
                bb_pkg::REG_LED1:    apb_rdata_o[bb_pkg::LED_DEPTH-1:0] = cfg_q.led1;
                bb_pkg::REG_STATUS:  apb_rdata_o[1:0] = {usb_rd_empty_i, usb_wr_full_i};
                bb_pkg::REG_FE_CTRL: begin
                    apb_rdata_o[5:0]  = cfg_q.fe_a;
                    apb_rdata_o[13:8] = cfg_q.fe_b;
                end
                default: apb_rdata_o = '0;  // USB data word is push only
            endcase
        end
    end

endmodule

// File: hw/usb_route.sv
`timescale 1ns/1ps

module usb_route (
    input  logic                      clk,
    input  logic                      reset_i,
    input  bb_pkg::usb_src_e          src_i,
    input  bb_pkg::usb_word_t         raw_i,
    input  logic [bb_pkg::ADC_DW-1:0] adc_i,
    input  bb_pkg::usb_word_t         rd_i,
    input  logic                      wr_full_i,
    output bb_pkg::usb_word_t         wr_o,
    output logic                      rd_en_o
);

    bb_pkg::usb_word_t          wr_d;        // Selected word, before the flop
    logic [bb_pkg::USB_DW-1:0]  wr_data_q;
    logic [bb_pkg::USB_BEW-1:0] wr_be_q;
    logic                       wr_valid_q;

    // Source select
    always_comb begin
        wr_d = raw_i;
        case (src_i)
            bb_pkg::SRC_REGS: wr_d = raw_i;
            bb_pkg::SRC_IDLE: begin
                wr_d.data  = '0;
                wr_d.be    = '1;
                wr_d.valid = 1'b0;  // Nothing sent
            end
            bb_pkg::SRC_ADC: begin
                wr_d.data  = {{(bb_pkg::USB_DW - bb_pkg::ADC_DW){1'b0}}, adc_i};
                wr_d.be    = '1;
                wr_d.valid = 1'b1;  // Sample every cycle
            end
            bb_pkg::SRC_LOOP: wr_d = rd_i;  // Echo host data
            default:          wr_d = raw_i;
        endcase
    end

    // Read side pulls only for loopback and ADC streaming
    always_comb begin
        case (src_i)
            bb_pkg::SRC_LOOP: rd_en_o = !wr_full_i;  // Full stalls the echo
            bb_pkg::SRC_ADC:  rd_en_o = 1'b1;
            default:          rd_en_o = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= wr_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        wr_data_q <= wr_d.data;
        wr_be_q   <= wr_d.be;
    end

    assign wr_o = {wr_data_q, wr_be_q, wr_valid_q};

endmodule

// File: hw/led_ddac.sv
`timescale 1ns/1ps

module led_ddac (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic [bb_pkg::LED_DEPTH-1:0] level0_i,
    input  logic [bb_pkg::LED_DEPTH-1:0] level1_i,
    output logic [1:0]                   led_o
);

    logic [bb_pkg::LED_DEPTH-1:0] level [2];
    logic [bb_pkg::LED_DEPTH-1:0] acc_q [2];
    logic [bb_pkg::LED_DEPTH:0]   sum   [2];  // Carry in the top bit
    logic                         carry_q [2];

    assign level[0] = level0_i;
    assign level[1] = level1_i;

    // First-order delta-sigma, one per LED
    for (genvar i = 0; i < 2; i++) begin : g_ch
        assign sum[i] = {1'b0, acc_q[i]} + {1'b0, level[i]};

        always_ff @(posedge clk) begin
            if (reset_i) begin
                acc_q[i]   <= '0;
                carry_q[i] <= 1'b0;
            end else begin
                acc_q[i]   <= sum[i][bb_pkg::LED_DEPTH-1:0];  // Wraps mod 2^16
                carry_q[i] <= sum[i][bb_pkg::LED_DEPTH];      // Density = level / 2^16
            end
        end
    end

    assign led_o = {carry_q[1], carry_q[0]};

endmodule

// File: hw/ioexp_shift.sv
`timescale 1ns/1ps

module ioexp_shift (
    input  logic             clk,
    input  logic             reset_i,
    input  bb_pkg::fe_ctrl_t fe_a_i,
    input  bb_pkg::fe_ctrl_t fe_b_i,
    input  logic             dor_a_i,
    input  logic             dor_b_i,
    output logic             io_clk_o,
    output logic             io_data_o
);

    logic [bb_pkg::IOEXP_W-1:0]  word;      // Port 1 in 15:8, port 0 in 7:0
    logic [bb_pkg::IOEXP_W-1:0]  shift_q;
    logic [bb_pkg::IOEXP_CW-1:0] cnt_q;     // Frame slot
    logic                        in_bits;   // Slots 0..31 carry data
    logic                        sclk_n_q;  // Active-low copies of the pins
    logic                        sdata_n_q;

    //////////////////////////////
    // Expander word
    //////////////////////////////

    always_comb begin
        word     = '0;                                 // COM pins and spares low
        word[14] = !(dor_a_i || fe_a_i.led[2]);        // Red A lit on overrange
        word[13] = !(dor_b_i || fe_b_i.led[2]);
        word[11] = !(!dor_b_i && fe_b_i.led[1]);       // Green and blue dark on overrange
        word[10] = !(!dor_b_i && fe_b_i.led[0]);
        word[9]  = !(!dor_a_i && fe_a_i.led[1]);
        word[8]  = !(!dor_a_i && fe_a_i.led[0]);
        word[6]  = fe_a_i.amp_en;
        word[5]  = !fe_a_i.att[1];
        word[4]  = !fe_a_i.att[0];
        word[2]  = fe_b_i.amp_en;
        word[1]  = !fe_b_i.att[1];
        word[0]  = !fe_b_i.att[0];
    end

    //////////////////////////////
    // Frame timing
    //////////////////////////////

    assign in_bits = cnt_q < bb_pkg::IOEXP_CW'(2 * bb_pkg::IOEXP_W);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (cnt_q == bb_pkg::IOEXP_CW'(bb_pkg::IOEXP_FRAME - 1)) begin
            cnt_q <= '0;  // Next frame
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Even slot sets data with clock low, odd slot raises clock
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sclk_n_q  <= 1'b0;  // Pin clock idles high
            sdata_n_q <= 1'b0;
        end else begin
            sclk_n_q <= in_bits && !cnt_q[0];
            if (cnt_q == '0) begin
                sdata_n_q <= word[bb_pkg::IOEXP_W-1];    // MSB first
            end else if (in_bits && !cnt_q[0]) begin
                sdata_n_q <= shift_q[bb_pkg::IOEXP_W-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_q == '0) begin
            shift_q <= {word[bb_pkg::IOEXP_W-2:0], 1'b0};  // Latch at slot 0
        end else if (in_bits && !cnt_q[0]) begin
            shift_q <= shift_q << 1;
        end
    end

    // Board buffers invert both lines
    assign io_clk_o  = !sclk_n_q;
    assign io_data_o = !sdata_n_q;

endmodule

// File: hw/bb_top.sv
`timescale 1ns/1ps

module bb_top (
    input  logic                      clk,
    input  logic                      reset_i,
    input  bb_pkg::apb_req_t          apb_i,
    input  logic [bb_pkg::ADC_DW-1:0] adc_a_i,
    input  logic                      dor_a_i,
    input  logic                      dor_b_i,
    input  bb_pkg::usb_word_t         usb_rd_i,
    input  logic                      usb_rd_empty_i,
    input  logic                      usb_wr_full_i,
    output logic [bb_pkg::APB_DW-1:0] apb_rdata_o,
    output bb_pkg::usb_word_t         usb_wr_o,
    output logic                      usb_rd_en_o,
    output logic [1:0]                led_o,
    output logic                      ioexp_clk_o,
    output logic                      ioexp_data_o,
    output logic                      i2c_sel_o,
    output logic                      dac_dce_o
);

    bb_pkg::bb_cfg_t   cfg;      // Register block settings
    bb_pkg::usb_word_t usb_raw;  // Pushed by REG_USB_WDATA

    //////////////////////////////
    // Registers
    //////////////////////////////

    bb_regs i_bb_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .apb_i          (apb_i),
        .usb_wr_full_i  (usb_wr_full_i),
        .usb_rd_empty_i (usb_rd_empty_i),
        .apb_rdata_o    (apb_rdata_o),
        .cfg_o          (cfg),
        .usb_raw_o      (usb_raw)
    );

    assign i2c_sel_o = cfg.i2c_sel;  // Straight to the I2C buffers on the board
    assign dac_dce_o = cfg.dac_dce;

    //////////////////////////////
    // USB stream routing
    //////////////////////////////

    usb_route i_usb_route (
        .clk       (clk),
        .reset_i   (reset_i),
        .src_i     (cfg.usb_src),
        .raw_i     (usb_raw),
        .adc_i     (adc_a_i),
        .rd_i      (usb_rd_i),
        .wr_full_i (usb_wr_full_i),
        .wr_o      (usb_wr_o),
        .rd_en_o   (usb_rd_en_o)
    );

    led_ddac i_led_ddac (
        .clk      (clk),
        .reset_i  (reset_i),
        .level0_i (cfg.led0),
        .level1_i (cfg.led1),
        .led_o    (led_o)
    );

    // Front-end expander, red LEDs flag overrange
    ioexp_shift i_ioexp_shift (
        .clk       (clk),
        .reset_i   (reset_i),
        .fe_a_i    (cfg.fe_a),
        .fe_b_i    (cfg.fe_b),
        .dor_a_i   (dor_a_i),
        .dor_b_i   (dor_b_i),
        .io_clk_o  (ioexp_clk_o),
        .io_data_o (ioexp_data_o)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = !clk_o;  // 4 ns period
    end

    // Reset held for three rising edges, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// File: tb/bb_tb.sv
`timescale 1ns/1ps

module bb_tb;

    logic                      clk;
    logic                      reset_i;
    bb_pkg::apb_req_t          apb;
    logic [bb_pkg::ADC_DW-1:0] adc_a;
    logic                      dor_a;
    logic                      dor_b;
    bb_pkg::usb_word_t         usb_rd;
    logic                      rd_empty;
    logic                      wr_full;
    logic [bb_pkg::APB_DW-1:0] apb_rdata;
    bb_pkg::usb_word_t         usb_wr;
    logic                      usb_rd_en;
    logic [1:0]                led;
    logic                      ioexp_clk;
    logic                      ioexp_data;
    logic                      i2c_sel;
    logic                      dac_dce;
    logic [31:0]               cmds [0:159];  // Four words per record
    logic [15:0]               lfsr_q;

    tb_clock i_tb_clock (.clk_o(clk), .reset_o(reset_i));

    bb_top i_bb_top (
        .clk (clk), .reset_i (reset_i), .apb_i (apb), .adc_a_i (adc_a),
        .dor_a_i (dor_a), .dor_b_i (dor_b), .usb_rd_i (usb_rd),
        .usb_rd_empty_i (rd_empty), .usb_wr_full_i (wr_full),
        .apb_rdata_o (apb_rdata), .usb_wr_o (usb_wr), .usb_rd_en_o (usb_rd_en),
        .led_o (led), .ioexp_clk_o (ioexp_clk), .ioexp_data_o (ioexp_data),
        .i2c_sel_o (i2c_sel), .dac_dce_o (dac_dce)
    );

    //////////////////////////////
    // Error handling and compares
    //////////////////////////////

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [bb_pkg::APB_DW-1:0] got,
                              input logic [bb_pkg::APB_DW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_usb(input string name, input bb_pkg::usb_word_t got,
                             input bb_pkg::usb_word_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got data %h be %h valid %b, expected data %h be %h valid %b",
                     $time, name, got.data, got.be, got.valid, exp.data, exp.be, exp.valid);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        repeat (n) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};  // One step per bit
        end
    endtask

    function automatic logic [31:0] reg_addr(input logic [11:0] off);
        return {bb_pkg::BOARD_BASE[19:4], bb_pkg::REGS_PAGE, off};
    endfunction

    // Setup cycle, access cycle, then idle
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb = '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        apb.enable = 1'b1;
        @(negedge clk);
        apb = '0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        apb = '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: '0};
        @(negedge clk);
        apb.enable = 1'b1;
        @(negedge clk);
        data = apb_rdata;  // Still in access phase
        apb  = '0;
    endtask

    task automatic drive_stream();
        logic [31:0] v;
        draw_bits(32, v);
        usb_rd.data = v;
        draw_bits(4, v);
        usb_rd.be = v[3:0];
        draw_bits(1, v);
        usb_rd.valid = v[0];
        draw_bits(8, v);
        adc_a = v[7:0];
        draw_bits(1, v);
        wr_full = v[0];
    endtask

    //////////////////////////////
    // Behaviors
    //////////////////////////////

    task automatic run_push(input logic [31:0] data);
        bb_pkg::usb_word_t exp_w;
        int                k;
        exp_w = '{data: data, be: '1, valid: 1'b1};
        apb_write(reg_addr(bb_pkg::REG_USB_WDATA), data);
        for (k = 0; k < 6; k++) begin
            check_bit("usb_wr_o.valid", usb_wr.valid, k == 1);  // Second cycle after the write
            if (k == 1) check_usb("usb_wr_o", usb_wr, exp_w);
            @(negedge clk);
        end
    endtask

    task automatic run_stream(input logic [1:0] src, input int cycles);
        bb_pkg::usb_word_t         rd_prev;
        bb_pkg::usb_word_t         exp_w;
        logic [bb_pkg::ADC_DW-1:0] adc_prev;
        logic                      full_prev;
        int                        k;
        apb_write(reg_addr(bb_pkg::REG_CTRL), {30'h0, src});
        drive_stream();
        for (k = 0; k < cycles; k++) begin
            rd_prev   = usb_rd;
            adc_prev  = adc_a;
            full_prev = wr_full;
            @(negedge clk);
            case (bb_pkg::usb_src_e'(src))
                bb_pkg::SRC_ADC: begin
                    exp_w = '{data: {24'h0, adc_prev}, be: '1, valid: 1'b1};
                    check_usb("usb_wr_o", usb_wr, exp_w);
                    check_bit("usb_rd_en_o", usb_rd_en, 1'b1);
                end
                bb_pkg::SRC_IDLE: begin
                    check_bit("usb_wr_o.valid", usb_wr.valid, 1'b0);
                    check_word("usb_wr_o.data", usb_wr.data, '0);
                    check_bit("usb_rd_en_o", usb_rd_en, 1'b0);
                end
                bb_pkg::SRC_LOOP: begin
                    check_usb("usb_wr_o", usb_wr, rd_prev);  // Echo of last cycle
                    check_bit("usb_rd_en_o", usb_rd_en, !full_prev);
                end
                default: check_bit("usb_rd_en_o", usb_rd_en, 1'b0);
            endcase
            drive_stream();
        end
        wr_full = 1'b0;
    endtask

    task automatic run_led(input logic [15:0] l0, input logic [15:0] l1,
                           input logic [31:0] exp);
        int n0;
        int n1;
        int k;
        apb_write(reg_addr(bb_pkg::REG_LED0), {16'h0, l0});
        apb_write(reg_addr(bb_pkg::REG_LED1), {16'h0, l1});
        @(negedge clk);  // Spare cycle before counting
        n0 = 0;
        n1 = 0;
        for (k = 0; k < 65536; k++) begin
            @(negedge clk);
            n0 += int'(led[0]);
            n1 += int'(led[1]);
        end
        check_word("led_o high count", {n1[15:0], n0[15:0]}, exp);
    endtask

    task automatic run_frame(input logic [31:0] fe, input logic [1:0] dor,
                             input logic [15:0] exp_word);
        int          high_run;
        int          cnt;
        int          nbits;
        logic        prev_clk;
        logic [15:0] samples;
        apb_write(reg_addr(bb_pkg::REG_FE_CTRL), fe);
        dor_a    = dor[0];
        dor_b    = dor[1];
        high_run = 0;
        cnt      = 0;
        // Idle gap is the only place the clock stays high twice
        while (high_run < 2) begin
            @(negedge clk);
            high_run = ioexp_clk ? high_run + 1 : 0;
            cnt++;
            if (cnt > 2 * bb_pkg::IOEXP_FRAME) begin
                $display("Timeout: expander clock never showed its idle gap");
                abort_run();
            end
        end
        prev_clk = ioexp_clk;
        samples  = '0;
        nbits    = 0;
        cnt      = 0;
        while (nbits < bb_pkg::IOEXP_W) begin
            @(negedge clk);
            if (ioexp_clk && !prev_clk) begin
                samples = {samples[14:0], ioexp_data};  // MSB arrives first
                nbits++;
            end
            prev_clk = ioexp_clk;
            cnt++;
            if (cnt > 2 * bb_pkg::IOEXP_FRAME) begin
                $display("Timeout: expander frame ended with fewer than 16 clock pulses");
                abort_run();
            end
        end
        check_word("ioexp_data_o frame", {16'h0, samples}, {16'h0, ~exp_word});  // Pins inverted
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        logic [31:0] rdata;
        int          rec;
        int          cnt;
        apb      = '0;
        adc_a    = '0;
        dor_a    = 1'b0;
        dor_b    = 1'b0;
        usb_rd   = '0;
        rd_empty = 1'b0;
        wr_full  = 1'b0;
        lfsr_q   = 16'd48;  // Seed
        $readmemh("tb/bb_input.txt", cmds);
        cnt = 0;
        while (reset_i !== 1'b0) begin
            @(negedge clk);
            cnt++;
            if (cnt > 20) begin
                $display("Timeout: reset was never released");
                abort_run();
            end
        end
        @(negedge clk);
        check_bit("usb_wr_o.valid", usb_wr.valid, 1'b0);
        check_bit("usb_rd_en_o", usb_rd_en, 1'b0);
        check_bit("led_o[0]", led[0], 1'b0);
        check_bit("led_o[1]", led[1], 1'b0);
        rec = 0;
        while (4 * rec + 3 < $size(cmds) && cmds[4 * rec] !== 32'hF) begin
            op = cmds[4 * rec];
            a  = cmds[4 * rec + 1];
            b  = cmds[4 * rec + 2];
            e  = cmds[4 * rec + 3];
            case (op)
                32'h1: apb_write(a, b);
                32'h2: begin
                    apb_read(a, rdata);
                    check_word("apb_rdata_o", rdata, e);
                    if (a == reg_addr(bb_pkg::REG_CTRL)) begin
                        check_bit("i2c_sel_o", i2c_sel, e[4]);  // Pins follow the control bits
                        check_bit("dac_dce_o", dac_dce, e[8]);
                    end
                end
                32'h3: begin
                    @(negedge clk);
                    wr_full  = b[0];
                    rd_empty = b[1];
                end
                32'h4: run_push(b);
                32'h5: run_led(a[15:0], b[15:0], e);
                32'h6: run_stream(a[1:0], int'(b));
                32'h7: run_frame(a, b[1:0], e[15:0]);
                default: begin
                    $display("Unknown command %h in record %0d", op, rec);
                    abort_run();
                end
            endcase
            rec++;
        end
        if (4 * rec + 3 >= $size(cmds)) begin
            $display("Command file has no end record");
            abort_run();
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// File: tb/bb_input.txt
// Columns: command, argument A, argument B, expected value (all hex)
// 1 write A=addr B=data, 2 read A=addr, 3 flags B={rd_empty,wr_full}, 4 push B=data
// 5 LED A,B=levels E={cnt1,cnt0}, 6 stream A=src B=cycles, 7 expander A=fe B=dor E=word, F end
2 43C04000 00000000 00000000  // Control after reset
2 43C04014 00000000 00000000  // Front end after reset
1 43C04000 FFFFFFFF 00000000
2 43C04000 00000000 00000113  // Only defined bits
1 43C04004 12345678 00000000
2 43C04004 00000000 00005678
1 43C04008 0000ABCD 00000000
2 43C04008 00000000 0000ABCD
1 43C04014 FFFF3F2A 00000000
2 43C04014 00000000 00003F2A
2 43C0400C 00000000 00000000  // Push word is write only
2 43C04018 00000000 00000000  // Hole in the page
2 43C05000 00000000 00000000  // Next page
2 53C04000 00000000 00000000  // Other base
3 00000000 00000001 00000000
2 43C04010 00000000 00000001
3 00000000 00000002 00000000
2 43C04010 00000000 00000002
3 00000000 00000000 00000000
1 43C04000 00000000 00000000  // Back to register source
4 00000000 CAFEF00D 00000000
4 00000000 00000001 00000000
6 00000002 00000020 00000000  // ADC stream
6 00000001 00000010 00000000  // Idle
6 00000003 00000030 00000000  // Loopback
5 00004000 00000001 00014000
5 0000FFFF 00008001 8001FFFF
7 0000231C 00000000 00002361
7 0000231C 00000003 00000F61  // Both overrange
7 0000231C 00000002 00000F61
7 0000043B 00000000 00004C43
7 0000043B 00000001 00000F43
F 00000000 00000000 00000000

// File: files.f
common/bb_pkg.sv
regs/bb_regs.sv
hw/usb_route.sv
hw/led_ddac.sv
hw/ioexp_shift.sv
hw/bb_top.sv
tb/tb_clock.sv
tb/bb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module bb_tb -f files.f --Mdir obj_dir -o bb_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/bb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
